/* hw/scopeCtrlPkg.sv */
// shared opcodes, widths, reset values and the channel-select union; imported by the scope RTL
package scopeCtrlPkg;

	localparam int ramWidth = 12; // sample address width

	localparam logic [ramWidth-1:0] trigPointMin = 12'd4; // trigger point clamp, low end
	localparam logic [ramWidth-1:0] trigPointMax = 12'd4080; // 16 samples short of the top
	localparam logic [4:0] downsampleMax = 5'd30; // log2 downsample clamp

	localparam logic [7:0] trigThreshRst = 8'h80; // mid scale
	localparam logic [3:0] trigChannelsRst = 4'b1111; // all channels armed
	localparam logic [3:0] trigTypeRst = 4'b0001; // rising edge
	localparam logic [ramWidth-1:0] trigPointRst = 12'd1024; // a quarter into the buffer
	localparam logic [4:0] downsampleRst = 5'd1;
	localparam logic [7:0] pwmRst = 8'd58; // about 22.7 percent duty
	localparam logic rollingRst = 1'b1;
	localparam logic [7:0] myIdRst = 8'd200; // no ID assigned yet

	localparam logic [7:0] opAssignBase = 8'd0; // 0..9 assign ID
	localparam logic [7:0] opSelectBase = 8'd10; // 10..19 select board
	localparam logic [7:0] opLastBase = 8'd20; // 20..29 mark last board
	localparam logic [7:0] opPrime = 8'd100;
	localparam logic [7:0] opRollOn = 8'd101;
	localparam logic [7:0] opRollOff = 8'd102;
	localparam logic [7:0] opTrigPoint = 8'd121; // two args, high byte first
	localparam logic [7:0] opDownsample = 8'd124;
	localparam logic [7:0] opThresh = 8'd127;
	localparam logic [7:0] opTrigType = 8'd128;
	localparam logic [7:0] opTrigTot = 8'd129; // two args, high byte first
	localparam logic [7:0] opTrigChan = 8'd130;
	localparam logic [7:0] opDelayRead = 8'd132;
	localparam logic [7:0] opCarryRead = 8'd133;
	localparam logic [7:0] opGain = 8'd134;
	localparam logic [7:0] opPwm = 8'd135; // channel byte then value byte

	localparam logic [1:0] pwmRate = 2'd2; // pwm counter steps every pwmRate+1 clocks
	localparam int heartbeatBit = 26; // free-running counter bit for the last-board blink

	// one channel byte, seen raw or as board*4 + channel
	typedef union packed {
		logic [7:0] raw;
		struct packed {
			logic [5:0] board; // board ID that owns the channel
			logic [1:0] chan; // channel on that board
		} field;
	} chanSelT;

endpackage

/* hw/settingsBus.sv */
// decoded setting command from the chain parser to the acquisition settings registers
`timescale 1ns/1ps

interface settingsBus;
	logic cmdValid; // one-cycle pulse, command complete
	logic [7:0] opcode; // opcode of the completed command
	logic [7:0] arg0; // first argument byte
	logic [7:0] arg1; // second argument byte, two-arg opcodes only

	modport parser (
		output cmdValid,
		output opcode,
		output arg0,
		output arg1
	);

	modport settings (
		input cmdValid,
		input opcode,
		input arg0,
		input arg1
	);
endinterface

/* hw/chainParser.sv */
// serial command parser for one board in the chain; keeps ID and role, forwards bytes downstream
`timescale 1ns/1ps

module chainParser (
	input  logic clk,
	input  logic rstN,
	input  logic rxReady, // one-cycle strobe per received byte
	input  logic [7:0] rxData,
	output logic [7:0] comData, // byte forwarded to the next board
	output logic newComData, // one-cycle strobe with comData
	output logic [7:0] myId,
	output logic [1:0] masterClock, // 0 own master, 1 slave
	output logic serialPassthrough,
	output logic imTheLast,
	output logic rollingTrigger,
	output logic getExtData, // prime pulse
	output logic respReq, // counter readout request
	output logic respSel, // 0 delay counter, 1 carry counter
	settingsBus.parser setBus
);
	import scopeCtrlPkg::*;

	logic collecting; // 0 waiting for opcode, 1 collecting args
	logic [1:0] argsLeft; // argument bytes still expected
	logic argIdx; // next arg goes to arg0 or arg1
	logic [1:0] argsNeeded; // arg count of the byte on rxData as an opcode
	logic [7:0] selId; // board addressed by a select opcode
	logic [7:0] lastId; // board addressed by a last-board opcode
	logic fwd; // byte on rxData goes downstream
	logic [7:0] fwdByte; // what goes downstream
	logic isCounterRd; // 132 or 133

	assign selId = rxData - opSelectBase;
	assign lastId = rxData - opLastBase;
	assign isCounterRd = (rxData == opDelayRead) || (rxData == opCarryRead);

	always_comb begin
		case (rxData)
			opTrigPoint, opTrigTot, opPwm: argsNeeded = 2'd2;
			opDownsample, opThresh, opTrigType, opTrigChan, opGain: argsNeeded = 2'd1;
			default: argsNeeded = 2'd0; // no args, or unknown opcode
		endcase
	end

	// forward decision for the current byte
	always_comb begin
		fwd = 1'b0;
		fwdByte = rxData;
		if (collecting) begin
			fwd = 1'b1; // args of a kept command always travel on
		end else if (rxData < opSelectBase) begin
			fwd = 1'b1;
			fwdByte = rxData + 8'd1; // next board gets the next ID
		end else if (rxData < opLastBase) begin
			fwd = (selId != myId); // selected board swallows it
		end else if (rxData < opLastBase + 8'd10) begin
			fwd = 1'b1;
		end else begin
			case (rxData)
				opPrime, opRollOn, opRollOff: fwd = 1'b1;
				opDelayRead, opCarryRead: fwd = serialPassthrough; // only if someone else answers
				default: fwd = (argsNeeded != 2'd0); // kept settings; unknowns dropped
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			collecting <= 1'b0;
			argsLeft <= 2'd0;
			argIdx <= 1'b0;
			newComData <= 1'b0;
			getExtData <= 1'b0;
			respReq <= 1'b0;
			setBus.cmdValid <= 1'b0;
			myId <= myIdRst;
			masterClock <= 2'b00;
			serialPassthrough <= 1'b0;
			imTheLast <= 1'b0;
			rollingTrigger <= rollingRst;
		end else begin
			newComData <= rxReady && fwd;
			getExtData <= 1'b0; // strobes default low
			respReq <= 1'b0;
			setBus.cmdValid <= 1'b0;
			if (rxReady) begin
				if (collecting) begin
					argIdx <= 1'b1;
					argsLeft <= argsLeft - 2'd1;
					if (argsLeft == 2'd1) begin
						collecting <= 1'b0; // last arg in
						setBus.cmdValid <= 1'b1;
					end
				end else if (rxData < opSelectBase) begin
					myId <= rxData - opAssignBase;
					masterClock <= (rxData == opAssignBase) ? 2'b00 : 2'b01; // board 0 keeps its clock
				end else if (rxData < opLastBase) begin
					serialPassthrough <= (selId != myId);
				end else if (rxData < opLastBase + 8'd10) begin
					imTheLast <= (lastId == myId);
				end else begin
					if (rxData == opPrime) getExtData <= 1'b1;
					if (rxData == opRollOn) rollingTrigger <= 1'b1;
					if (rxData == opRollOff) rollingTrigger <= 1'b0;
					if (isCounterRd && !serialPassthrough) respReq <= 1'b1; // we answer
					if (argsNeeded != 2'd0) begin
						collecting <= 1'b1;
						argsLeft <= argsNeeded;
						argIdx <= 1'b0;
					end
				end
			end
		end
	end

	// data path, qualified by the strobes above
	always_ff @(posedge clk) begin
		if (rxReady && fwd) comData <= fwdByte;
		if (rxReady && !collecting) setBus.opcode <= rxData;
		if (rxReady && !collecting && isCounterRd) respSel <= (rxData == opCarryRead);
		if (rxReady && collecting) begin
			if (!argIdx) setBus.arg0 <= rxData;
			else setBus.arg1 <= rxData;
		end
	end

endmodule

/* hw/acqSettings.sv */
// trigger and front-end setting registers, loaded from decoded commands on the settings bus
`timescale 1ns/1ps

module acqSettings (
	input  logic clk,
	input  logic rstN,
	settingsBus.settings setBus,
	input  logic [7:0] myId,
	output logic [scopeCtrlPkg::ramWidth-1:0] triggerPoint,
	output logic [4:0] downsample, // log2 of samples skipped
	output logic [7:0] trigThresh,
	output logic [3:0] triggerType,
	output logic [scopeCtrlPkg::ramWidth:0] triggerTot, // time over threshold
	output logic [3:0] trigChannels, // per-channel trigger enable
	output logic [3:0] gainSw, // per-channel gain switch
	output logic [7:0] pwmValue0, // offset codes for offsetPwm
	output logic [7:0] pwmValue1,
	output logic [7:0] pwmValue2,
	output logic [7:0] pwmValue3
);
	import scopeCtrlPkg::*;

	chanSelT chanSel; // arg0 seen as board/channel
	logic boardHit; // channel byte addresses this board
	logic [15:0] argWord; // both args, high byte first
	logic [ramWidth-1:0] trigPointNext; // clamped trigger point
	logic [4:0] downsampleNext; // clamped downsample

	assign chanSel.raw = setBus.arg0;
	assign boardHit = ({2'b00, chanSel.field.board} == myId);
	assign argWord = {setBus.arg0, setBus.arg1};

	always_comb begin
		if (argWord > 16'(trigPointMax)) trigPointNext = trigPointMax;
		else if (argWord < 16'(trigPointMin)) trigPointNext = trigPointMin;
		else trigPointNext = argWord[ramWidth-1:0];
	end

	assign downsampleNext = (setBus.arg0 > 8'(downsampleMax)) ? downsampleMax : setBus.arg0[4:0];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			triggerPoint <= trigPointRst;
			downsample <= downsampleRst;
			trigThresh <= trigThreshRst;
			triggerType <= trigTypeRst;
			triggerTot <= '0;
			trigChannels <= trigChannelsRst;
			gainSw <= 4'b0000; // low gain on every channel
			pwmValue0 <= pwmRst;
			pwmValue1 <= pwmRst;
			pwmValue2 <= pwmRst;
			pwmValue3 <= pwmRst;
		end else if (setBus.cmdValid) begin
			case (setBus.opcode)
				opTrigPoint: triggerPoint <= trigPointNext;
				opDownsample: downsample <= downsampleNext;
				opThresh: trigThresh <= setBus.arg0;
				opTrigType: triggerType <= setBus.arg0[3:0];
				opTrigTot: triggerTot <= argWord[ramWidth:0];
				opTrigChan: begin
					if (boardHit) begin
						trigChannels[chanSel.field.chan] <= ~trigChannels[chanSel.field.chan]; // toggle
					end
				end
				opGain: begin
					if (boardHit) gainSw[chanSel.field.chan] <= ~gainSw[chanSel.field.chan];
				end
				opPwm: begin
					if (boardHit) begin
						case (chanSel.field.chan)
							2'd0: pwmValue0 <= setBus.arg1;
							2'd1: pwmValue1 <= setBus.arg1;
							2'd2: pwmValue2 <= setBus.arg1;
							default: pwmValue3 <= setBus.arg1;
						endcase
					end
				end
				default: ; // not a setting, leave registers alone
			endcase
		end
	end

endmodule

/* hw/offsetPwm.sv */
// four PWM outputs for the front-end offset voltages, one comparator per channel
`timescale 1ns/1ps

module offsetPwm (
	input  logic clk,
	input  logic rstN,
	input  logic [7:0] pwmValue0,
	input  logic [7:0] pwmValue1,
	input  logic [7:0] pwmValue2,
	input  logic [7:0] pwmValue3,
	output logic [3:0] offset // filtered off-chip into DC levels
);
	import scopeCtrlPkg::*;

	logic [1:0] rateCnt; // clock divider
	logic [7:0] pwmCnt; // sawtooth, one period is 256*(pwmRate+1) clocks

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rateCnt <= 2'd0;
			pwmCnt <= 8'd0;
		end else if (rateCnt == pwmRate) begin
			rateCnt <= 2'd0;
			pwmCnt <= pwmCnt + 8'd1; // wraps freely
		end else begin
			rateCnt <= rateCnt + 2'd1;
		end
	end

	// high while code is above the sawtooth
	assign offset[0] = (pwmValue0 > pwmCnt);
	assign offset[1] = (pwmValue1 > pwmCnt);
	assign offset[2] = (pwmValue2 > pwmCnt);
	assign offset[3] = (pwmValue3 > pwmCnt);

endmodule

/* hw/counterResponder.sv */
// answers a counter query with one byte on the serial transmitter once it is free
`timescale 1ns/1ps

module counterResponder (
	input  logic clk,
	input  logic rstN,
	input  logic respReq, // one-cycle request from the parser
	input  logic respSel, // 0 delay, 1 carry
	input  logic [7:0] delayCounter, // TDC fine count
	input  logic [7:0] carryCounter, // TDC carry chain count
	input  logic txBusy,
	output logic txStart, // one-cycle send strobe
	output logic [7:0] txData
);

	logic pending; // byte latched, waiting for the transmitter
	logic sendNow; // transmitter free with a byte waiting

	assign sendNow = pending && !txBusy;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pending <= 1'b0;
			txStart <= 1'b0;
		end else begin
			txStart <= sendNow;
			if (sendNow) pending <= 1'b0;
			else if (respReq) pending <= 1'b1; // requests while pending are dropped
		end
	end

	// snapshot of the counter, taken at the request
	always_ff @(posedge clk) begin
		if (respReq && !pending) txData <= respSel ? carryCounter : delayCounter;
	end

endmodule

/* hw/idLeds.sv */
// drives the three board LEDs with the ID, a last-board heartbeat and send activity
`timescale 1ns/1ps

module idLeds (
	input  logic clk,
	input  logic rstN,
	input  logic [7:0] myId,
	input  logic imTheLast,
	input  logic txStart, // flash on each sent byte
	output logic led1, // LEDs are active low
	output logic led2,
	output logic led3
);
	import scopeCtrlPkg::*;

	logic [heartbeatBit:0] beatCnt; // free-running, MSB is the blink
	logic allOn;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) beatCnt <= '0;
		else beatCnt <= beatCnt + 1'b1;
	end

	assign allOn = (imTheLast && beatCnt[heartbeatBit]) || txStart;

	always_comb begin
		if (allOn) begin
			{led3, led2, led1} = 3'b000;
		end else if (myId <= 8'd4) begin
			{led3, led2, led1} = ~myId[2:0]; // binary ID, lit bit is a 1
		end else begin
			{led3, led2, led1} = 3'b111; // unassigned or large ID shows dark
		end
	end

endmodule

/* hw/scopeProcessor.sv */
// top level of the board command processor, wiring parser, settings, PWM, responder and LEDs
`timescale 1ns/1ps

module scopeProcessor (
	input  logic clk,
	input  logic rstN,
	input  logic rxReady,
	input  logic [7:0] rxData,
	output logic [7:0] comData,
	output logic newComData,
	output logic [1:0] masterClock,
	output logic serialPassthrough,
	output logic imTheLast,
	output logic rollingTrigger,
	output logic getExtData,
	input  logic txBusy,
	output logic txStart,
	output logic [7:0] txData,
	input  logic [7:0] delayCounter,
	input  logic [7:0] carryCounter,
	output logic [scopeCtrlPkg::ramWidth-1:0] triggerPoint,
	output logic [4:0] downsample,
	output logic [7:0] trigThresh,
	output logic [3:0] triggerType,
	output logic [scopeCtrlPkg::ramWidth:0] triggerTot,
	output logic [3:0] trigChannels,
	output logic [3:0] gainSw,
	output logic [3:0] offset,
	output logic led1,
	output logic led2,
	output logic led3
);

	logic [7:0] myId;
	logic respReq;
	logic respSel;
	logic [7:0] pwmValue0;
	logic [7:0] pwmValue1;
	logic [7:0] pwmValue2;
	logic [7:0] pwmValue3;

	settingsBus setBus (); // parser to settings

	chainParser chainParser_inst (
		.clk, .rstN, .rxReady, .rxData, .comData, .newComData, .myId,
		.masterClock, .serialPassthrough, .imTheLast, .rollingTrigger,
		.getExtData, .respReq, .respSel, .setBus(setBus.parser)
	);

	acqSettings acqSettings_inst (
		.clk, .rstN, .setBus(setBus.settings), .myId, .triggerPoint, .downsample,
		.trigThresh, .triggerType, .triggerTot, .trigChannels, .gainSw,
		.pwmValue0, .pwmValue1, .pwmValue2, .pwmValue3
	);

	offsetPwm offsetPwm_inst (
		.clk, .rstN, .pwmValue0, .pwmValue1, .pwmValue2, .pwmValue3, .offset
	);

	counterResponder counterResponder_inst (
		.clk, .rstN, .respReq, .respSel, .delayCounter, .carryCounter,
		.txBusy, .txStart, .txData
	);

	idLeds idLeds_inst (
		.clk, .rstN, .myId, .imTheLast, .txStart, .led1, .led2, .led3
	);

endmodule

/* tb/scopeProcessorTb.sv */
// directed testbench for the board command processor; run through vlog.f with scopeProcessorTb as top
`timescale 1ns/1ps

module scopeProcessorTb;
	import scopeCtrlPkg::*;

	localparam int timeoutCycles = 20000; // about twenty times the length of all tests

	logic clk = 1'b0;
	logic rstN;
	logic rxReady;
	logic [7:0] rxData;
	logic [7:0] comData;
	logic newComData;
	logic [1:0] masterClock;
	logic serialPassthrough;
	logic imTheLast;
	logic rollingTrigger;
	logic getExtData;
	logic txBusy;
	logic txStart;
	logic [7:0] txData;
	logic [7:0] delayCounter;
	logic [7:0] carryCounter;
	logic [ramWidth-1:0] triggerPoint;
	logic [4:0] downsample;
	logic [7:0] trigThresh;
	logic [3:0] triggerType;
	logic [ramWidth:0] triggerTot;
	logic [3:0] trigChannels;
	logic [3:0] gainSw;
	logic [3:0] offset;
	logic led1;
	logic led2;
	logic led3;

	integer seed = 32'h946adc64;
	logic holdBusy = 1'b0; // test forces the transmitter busy
	int busyLeft = 0; // cycles the transmitter model stays busy
	int cycleCount = 0;

	scopeProcessor scopeProcessor_inst (.*);

	always #20 clk = ~clk; // 40 ns period

	// transmitter model, random busy time after every sent byte
	always @(negedge clk) begin
		if (busyLeft > 0) busyLeft = busyLeft - 1;
		if (txStart) busyLeft = 1 + int'($unsigned($random(seed)) % 8);
	end
	assign txBusy = holdBusy || (busyLeft != 0);

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
			reportFailure();
		end
	end

	task automatic reportFailure();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED: %s is 0x%h, expected 0x%h", name, got, exp);
			reportFailure();
		end
	endtask

	// one byte with a one-cycle rxReady, returns where first-level effects are visible
	task automatic sendByte(input logic [7:0] b);
		@(negedge clk);
		rxData = b;
		rxReady = 1'b1;
		@(negedge clk);
		rxReady = 1'b0;
	endtask

	task automatic sendAndCheckFwd(input logic [7:0] b, input logic expFwd,
			input logic [7:0] expByte);
		sendByte(b);
		expectEq("newComData", 32'(newComData), 32'(expFwd));
		if (expFwd) expectEq("comData", 32'(comData), 32'(expByte));
	endtask

	// kept setting command, every byte forwarded unchanged, returns once registers settle
	task automatic sendCommand(input logic [7:0] op, input int nArgs, input logic [7:0] a0,
			input logic [7:0] a1);
		sendAndCheckFwd(op, 1'b1, op);
		if (nArgs > 0) sendAndCheckFwd(a0, 1'b1, a0);
		if (nArgs > 1) sendAndCheckFwd(a1, 1'b1, a1);
		@(negedge clk); // one cycle after cmdValid
	endtask

	task automatic expectNoTxStart(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			expectEq("txStart", 32'(txStart), 32'd0);
		end
	endtask

	task automatic waitTxStart(input int limit);
		int n;
		n = 0;
		while (!txStart) begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				$display("txStart did not pulse within %0d cycles after txBusy dropped", limit);
				reportFailure();
			end
		end
	endtask

	task automatic checkResetState();
		expectEq("txStart", 32'(txStart), 32'd0);
		expectEq("newComData", 32'(newComData), 32'd0);
		expectEq("getExtData", 32'(getExtData), 32'd0);
		expectEq("serialPassthrough", 32'(serialPassthrough), 32'd0);
		expectEq("imTheLast", 32'(imTheLast), 32'd0);
		expectEq("masterClock", 32'(masterClock), 32'd0);
		expectEq("triggerPoint", 32'(triggerPoint), 32'd1024);
		expectEq("trigThresh", 32'(trigThresh), 32'h80);
		expectEq("trigChannels", 32'(trigChannels), 32'hf);
		expectEq("rollingTrigger", 32'(rollingTrigger), 32'd1);
		expectEq("leds", 32'({led3, led2, led1}), 32'b111); // ID 200 shows dark
	endtask

	task automatic idAssignTest();
		sendAndCheckFwd(8'd0, 1'b1, 8'd1); // next board gets ID 1
		expectEq("masterClock", 32'(masterClock), 32'd0);
		@(negedge clk);
		expectEq("newComData", 32'(newComData), 32'd0); // single-cycle strobe
		sendAndCheckFwd(8'd3, 1'b1, 8'd4);
		expectEq("masterClock", 32'(masterClock), 32'd1);
		expectEq("leds", 32'({led3, led2, led1}), 32'b100); // ID 3, active low
	endtask

	task automatic chainSelectTest();
		sendAndCheckFwd(8'd23, 1'b1, 8'd23); // last board is 3
		expectEq("imTheLast", 32'(imTheLast), 32'd1);
		sendAndCheckFwd(8'd15, 1'b1, 8'd15); // board 5 selected, not us
		expectEq("serialPassthrough", 32'(serialPassthrough), 32'd1);
		sendAndCheckFwd(opCarryRead, 1'b1, opCarryRead); // someone else answers
		expectNoTxStart(8);
		sendAndCheckFwd(8'd13, 1'b0, 8'd0); // we are selected, swallowed
		expectEq("serialPassthrough", 32'(serialPassthrough), 32'd0);
	endtask

	task automatic readOneCounter(input logic [7:0] op, input logic [7:0] expByte);
		holdBusy = 1'b1;
		sendAndCheckFwd(op, 1'b0, 8'd0); // answered here, not forwarded
		expectNoTxStart(10);
		holdBusy = 1'b0;
		waitTxStart(40);
		expectEq("txData", 32'(txData), 32'(expByte));
		expectEq("leds", 32'({led3, led2, led1}), 32'b000); // flash while sending
		@(negedge clk);
		expectEq("txStart", 32'(txStart), 32'd0);
	endtask

	task automatic counterReadTest();
		delayCounter = 8'($random(seed));
		carryCounter = 8'($random(seed));
		if (carryCounter == delayCounter) carryCounter = ~delayCounter; // keep them apart
		readOneCounter(opDelayRead, delayCounter);
		readOneCounter(opCarryRead, carryCounter);
	endtask

	task automatic settingsTest();
		sendCommand(opTrigPoint, 2, 8'h0f, 8'hff); // 4095 clamps down
		expectEq("triggerPoint", 32'(triggerPoint), 32'd4080);
		sendCommand(opTrigPoint, 2, 8'h00, 8'h01); // 1 clamps up
		expectEq("triggerPoint", 32'(triggerPoint), 32'd4);
		sendCommand(opDownsample, 1, 8'd40, 8'd0);
		expectEq("downsample", 32'(downsample), 32'd30);
		sendCommand(opThresh, 1, 8'h3c, 8'd0);
		expectEq("trigThresh", 32'(trigThresh), 32'h3c);
		sendCommand(opTrigType, 1, 8'h05, 8'd0);
		expectEq("triggerType", 32'(triggerType), 32'h5);
		sendCommand(opTrigTot, 2, 8'h12, 8'h34); // high byte first
		expectEq("triggerTot", 32'(triggerTot), 32'h1234);
		sendAndCheckFwd(opRollOff, 1'b1, opRollOff);
		expectEq("rollingTrigger", 32'(rollingTrigger), 32'd0);
		sendAndCheckFwd(opRollOn, 1'b1, opRollOn);
		expectEq("rollingTrigger", 32'(rollingTrigger), 32'd1);
		sendAndCheckFwd(opPrime, 1'b1, opPrime);
		expectEq("getExtData", 32'(getExtData), 32'd1);
		@(negedge clk);
		expectEq("getExtData", 32'(getExtData), 32'd0);
	endtask

	task automatic channelTest();
		chanSelT sel;
		sel.field.board = 6'd3;
		sel.field.chan = 2'd2;
		sendCommand(opTrigChan, 1, sel.raw, 8'd0);
		expectEq("trigChannels", 32'(trigChannels), 32'b1011); // bit 2 toggled off
		sendCommand(opGain, 1, sel.raw, 8'd0);
		expectEq("gainSw", 32'(gainSw), 32'b0100);
		sel.field.board = 6'd1; // another board's channel
		sendCommand(opTrigChan, 1, sel.raw, 8'd0);
		sendCommand(opGain, 1, sel.raw, 8'd0);
		expectEq("trigChannels", 32'(trigChannels), 32'b1011);
		expectEq("gainSw", 32'(gainSw), 32'b0100);
	endtask

	task automatic pwmTest();
		chanSelT sel;
		int high0;
		int high1;
		int high2;
		int high3;
		sel.field.board = 6'd3;
		sel.field.chan = 2'd1;
		high0 = 0;
		high1 = 0;
		high2 = 0;
		high3 = 0;
		sendCommand(opPwm, 2, sel.raw, 8'd100);
		repeat (768) begin // one full PWM period
			@(negedge clk);
			if (offset[0]) high0++;
			if (offset[1]) high1++;
			if (offset[2]) high2++;
			if (offset[3]) high3++;
		end
		expectEq("offset[1] high cycles", 32'(high1), 32'd300);
		expectEq("offset[0] high cycles", 32'(high0), 32'd174); // still the reset code 58
		expectEq("offset[2] high cycles", 32'(high2), 32'd174);
		expectEq("offset[3] high cycles", 32'(high3), 32'd174);
	endtask

	initial begin
		rstN = 1'b0;
		rxReady = 1'b0;
		rxData = 8'd0;
		delayCounter = 8'd0;
		carryCounter = 8'd0;
		repeat (16) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);
		checkResetState();
		idAssignTest();
		chainSelectTest();
		counterReadTest();
		settingsTest();
		channelTest();
		pwmTest();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* vlog.f */
hw/scopeCtrlPkg.sv
hw/settingsBus.sv
hw/chainParser.sv
hw/acqSettings.sv
hw/offsetPwm.sv
hw/counterResponder.sv
hw/idLeds.sv
hw/scopeProcessor.sv
tb/scopeProcessorTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log for the pass line
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f vlog.f \
	--top-module scopeProcessorTb --Mdir obj_dir -o simv; then
	echo "verilator compile failed"
	exit 1
fi

if ! ./obj_dir/simv > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation exited with an error"
	exit 1
fi

cat "$LOG"

if grep -q "ALL TESTS PASSED" "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi
